/* dma_config.svh */
/* Build-time sizes and ID constants for the DMA copy engine.
   Include wherever a width, the queue depth or the ID words are needed. */

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Data word width in bits
`define DMA_DATA_W 64

// Word address width, memory addresses wrap at this size
`define DMA_ADDR_W 16

// Length field width, counts words
`define DMA_LEN_W 16

// Descriptor slots in the queue
`define DMA_QUEUE_DEPTH 4

// Feature ID words returned by the register block
`define DMA_ID_L 64'h8d3b_51e2_0c47_a9f6
`define DMA_ID_H 64'h2f71_c6a0_94de_3b58

`endif

/* dma_regs_pkg.sv */
/* Register map of the DMA engine, shared by the register block and the testbench.
   Indices are AXI byte address bits 7 to 3. */

`default_nettype none

package dma_regs_pkg;

    // ==============================
    // Register indices
    // ==============================
    typedef enum logic [4:0] {
        REG_DFH        = 5'd0,
        REG_ID_L       = 5'd1,
        REG_ID_H       = 5'd2,
        REG_SRC        = 5'd3,
        REG_DEST       = 5'd4,
        REG_LEN        = 5'd5,
        REG_DESC_CTRL  = 5'd6,
        REG_STATUS     = 5'd7,
        REG_CONTROL    = 5'd8,
        REG_DONE_COUNT = 5'd9
    } dma_reg_e;

    // Status bits
    localparam int STAT_BUSY     = 0;
    localparam int STAT_EMPTY    = 1;
    localparam int STAT_FULL     = 2;
    localparam int STAT_OVERFLOW = 3;

    // Control bits, the clear bit is a strobe
    localparam int CTRL_RUN     = 0;
    localparam int CTRL_CLR_OVF = 1;

    // Descriptor control, go pushes the staged descriptor
    localparam int DESC_GO = 0;

    // Feature header: type 1 in [63:60], end of list in bit 40
    localparam logic [63:0] DFH_VALUE = 64'h1000_0100_0000_0000;

endpackage

`default_nettype wire

/* dma_xfer_pkg.sv */
/* Data, address and descriptor types used along the copy path.
   Imported by the queue user, controller, mover, top and testbench. */

`default_nettype none

package dma_xfer_pkg;

    `include "dma_config.svh"

    // One memory word
    typedef logic [`DMA_DATA_W-1:0] word_t;

    // Word address, not byte address
    typedef logic [`DMA_ADDR_W-1:0] addr_t;

    // Transfer length in words
    typedef logic [`DMA_LEN_W-1:0] len_t;

    // ==============================
    // Descriptor, 48 bits
    // ==============================
    typedef struct packed {
        addr_t src;
        addr_t dest;
        len_t  len;
    } dma_desc_t;

endpackage

`default_nettype wire

/* dma_csr_regs.sv */
/* AXI-lite register block: feature header, ID words, descriptor staging and status.
   One read and one write in flight at a time; a go write pushes the staged descriptor. */

`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_csr_regs
    import dma_regs_pkg::*, dma_xfer_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    // AXI-lite read
    input  logic        arvalid,
    output logic        arready,
    input  logic [7:0]  araddr,
    output logic        rvalid,
    input  logic        rready,
    output word_t       rdata,
    // AXI-lite write
    input  logic        awvalid,
    output logic        awready,
    input  logic [7:0]  awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  word_t       wdata,
    output logic        bvalid,
    input  logic        bready,
    // Descriptor queue
    output logic        push,
    output dma_desc_t   push_data,
    input  logic        queue_empty,
    input  logic        queue_full,
    input  logic        queue_dropped,
    // Controller
    input  logic        busy,
    input  logic [31:0] done_count,
    output logic        run
);

    // Captured requests
    logic      ar_pend;
    dma_reg_e  ar_idx_q;
    logic      aw_pend;
    dma_reg_e  aw_idx_q;
    logic      w_pend;
    word_t     wdata_q;

    // Staged descriptor and sticky overflow
    addr_t     src_q;
    addr_t     dest_q;
    len_t      len_q;
    logic      ovf_q;

    word_t     rd_word;
    logic      is_csr_read;
    logic      is_csr_write;

    // Request held for one cycle, then answered
    assign is_csr_read  = ar_pend;
    assign is_csr_write = aw_pend && w_pend;

    // Not pipelined, ready only with nothing pending
    assign arready = !ar_pend && !rvalid;
    assign awready = !aw_pend && !bvalid;
    assign wready  = !w_pend && !bvalid;

    assign push_data = '{src: src_q, dest: dest_q, len: len_q};

    // ==============================
    // Read path
    // ==============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ar_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (is_csr_read) begin
                ar_pend <= 1'b0;
                rvalid  <= 1'b1;
            end else if (arvalid && arready) begin
                ar_pend <= 1'b1;
            end
            // Response leaves once the host takes it
            if (!is_csr_read && rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Address and read data are payload
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_idx_q <= dma_reg_e'(araddr[7:3]);
        end
        if (is_csr_read) begin
            rdata <= rd_word;
        end
    end

    // Register read mux, unmapped indices read zero
    always_comb begin
        rd_word = '0;
        case (ar_idx_q)
            REG_DFH:        rd_word = DFH_VALUE;
            REG_ID_L:       rd_word = `DMA_ID_L;
            REG_ID_H:       rd_word = `DMA_ID_H;
            REG_SRC:        rd_word = word_t'(src_q);
            REG_DEST:       rd_word = word_t'(dest_q);
            REG_LEN:        rd_word = word_t'(len_q);
            REG_DESC_CTRL:  rd_word = '0;
            REG_STATUS: begin
                rd_word[STAT_BUSY]     = busy;
                rd_word[STAT_EMPTY]    = queue_empty;
                rd_word[STAT_FULL]     = queue_full;
                rd_word[STAT_OVERFLOW] = ovf_q;
            end
            REG_CONTROL:    rd_word[CTRL_RUN] = run;
            REG_DONE_COUNT: rd_word = word_t'(done_count);
            default:        rd_word = '0;
        endcase
    end

    // ==============================
    // Write path
    // ==============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (is_csr_write) begin
                aw_pend <= 1'b0;
                w_pend  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                // Halves may arrive in either order
                if (awvalid && awready) begin
                    aw_pend <= 1'b1;
                end
                if (wvalid && wready) begin
                    w_pend <= 1'b1;
                end
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_idx_q <= dma_reg_e'(awaddr[7:3]);
        end
        if (wvalid && wready) begin
            wdata_q <= wdata;
        end
    end

    // Decode writes into staged values, run and go
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            src_q  <= '0;
            dest_q <= '0;
            len_q  <= '0;
            run    <= 1'b0;
            ovf_q  <= 1'b0;
            push   <= 1'b0;
        end else begin
            push <= is_csr_write && (aw_idx_q == REG_DESC_CTRL) && wdata_q[DESC_GO];
            if (is_csr_write) begin
                case (aw_idx_q)
                    REG_SRC:  src_q  <= addr_t'(wdata_q);
                    REG_DEST: dest_q <= addr_t'(wdata_q);
                    REG_LEN:  len_q  <= len_t'(wdata_q);
                    REG_CONTROL: begin
                        run <= wdata_q[CTRL_RUN];
                        if (wdata_q[CTRL_CLR_OVF]) begin
                            ovf_q <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            // A drop in the same cycle wins over the clear
            if (queue_dropped) begin
                ovf_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* dma_desc_queue.sv */
/* Small synchronous FIFO with a type-parameter payload, head visible when not empty.
   Pushes into a full queue are discarded and flagged on dropped. */

`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_desc_queue
    import dma_xfer_pkg::*;
#(
    parameter type T     = dma_desc_t,
    parameter int  DEPTH = `DMA_QUEUE_DEPTH
) (
    input  logic clk,
    input  logic reset_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full,
    output logic dropped
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = slots[rd_ptr];

    // Storage, no reset on payload
    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    // ==============================
    // Pointers and occupancy
    // ==============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            dropped <= push && full;
            if (do_push) begin
                // Wrap explicitly so any depth works
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* dma_ctrl.sv */
/* Descriptor controller: pops the queue while run is set and hands each descriptor
   to the word mover over a four-phase handshake; counts completed descriptors. */

`timescale 1ns/1ps
`default_nettype none

module dma_ctrl
    import dma_xfer_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        run,
    input  logic        queue_empty,
    input  dma_desc_t   pop_data,
    input  logic        xfer_ack,
    output logic        pop,
    output logic        xfer_req,
    output dma_desc_t   xfer_desc,
    output logic        busy,
    output logic [31:0] done_count
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_WAIT_REL
    } ctrl_state_e;

    ctrl_state_e state;
    logic        start;

    // Nothing open, run set and work queued
    assign start = (state == ST_IDLE) && run && !queue_empty;

    // Busy from the pop until the mover drops its ack
    assign busy = (state != ST_IDLE);

    // ==============================
    // Handshake FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= ST_IDLE;
            pop        <= 1'b0;
            xfer_req   <= 1'b0;
            done_count <= '0;
        end else begin
            // Pop lasts one cycle
            pop <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        pop      <= 1'b1;
                        xfer_req <= 1'b1;
                        state    <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    // Mover finished all words
                    if (xfer_ack) begin
                        xfer_req   <= 1'b0;
                        done_count <= done_count + 1'b1;
                        state      <= ST_WAIT_REL;
                    end
                end
                ST_WAIT_REL: begin
                    if (!xfer_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Head descriptor held for the whole transfer
    always_ff @(posedge clk) begin
        if (start) begin
            xfer_desc <= pop_data;
        end
    end

endmodule

`default_nettype wire

/* dma_word_mover.sv */
/* Word copy datapath: reads each source word into a holding register, then writes it
   to the destination, every access a full four-phase cycle on the memory port. */

`timescale 1ns/1ps
`default_nettype none

module dma_word_mover
    import dma_xfer_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      xfer_req,
    input  dma_desc_t xfer_desc,
    output logic      xfer_ack,
    output logic      mem_req,
    output logic      mem_we,
    output addr_t     mem_addr,
    output word_t     mem_wdata,
    input  logic      mem_ack,
    input  word_t     mem_rdata
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD,
        ST_RD_REL,
        ST_WR,
        ST_WR_REL,
        ST_ACK
    } mover_state_e;

    mover_state_e state;
    len_t         idx;
    len_t         idx_nxt;
    word_t        hold_q;

    assign idx_nxt   = idx + len_t'(1);
    assign mem_wdata = hold_q;

    // ==============================
    // Copy FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            idx      <= '0;
            xfer_ack <= 1'b0;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            mem_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (xfer_req && xfer_desc.len == '0) begin
                        // Nothing to copy, acknowledge at once
                        xfer_ack <= 1'b1;
                        state    <= ST_ACK;
                    end else if (xfer_req) begin
                        idx      <= '0;
                        mem_req  <= 1'b1;
                        mem_we   <= 1'b0;
                        mem_addr <= xfer_desc.src;
                        state    <= ST_RD;
                    end
                end
                ST_RD: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_RD_REL;
                    end
                end
                ST_RD_REL: begin
                    // Write only after the read ack is gone
                    if (!mem_ack) begin
                        mem_req  <= 1'b1;
                        mem_we   <= 1'b1;
                        mem_addr <= xfer_desc.dest + idx;
                        state    <= ST_WR;
                    end
                end
                ST_WR: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_WR_REL;
                    end
                end
                ST_WR_REL: begin
                    if (!mem_ack && idx_nxt == xfer_desc.len) begin
                        mem_we   <= 1'b0;
                        xfer_ack <= 1'b1;
                        state    <= ST_ACK;
                    end else if (!mem_ack) begin
                        // Next word, address wraps by truncation
                        idx      <= idx_nxt;
                        mem_req  <= 1'b1;
                        mem_we   <= 1'b0;
                        mem_addr <= xfer_desc.src + idx_nxt;
                        state    <= ST_RD;
                    end
                end
                ST_ACK: begin
                    if (!xfer_req) begin
                        xfer_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read data captured while the ack is high
    always_ff @(posedge clk) begin
        if (state == ST_RD && mem_ack) begin
            hold_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* dma_top.sv */
/* Top of the DMA copy engine: register block, descriptor queue, controller and mover.
   AXI-lite on one side, four-phase word memory port on the other. */

`timescale 1ns/1ps
`default_nettype none

module dma_top
    import dma_xfer_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // AXI-lite
    input  logic       arvalid,
    output logic       arready,
    input  logic [7:0] araddr,
    output logic       rvalid,
    input  logic       rready,
    output word_t      rdata,
    input  logic       awvalid,
    output logic       awready,
    input  logic [7:0] awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  word_t      wdata,
    output logic       bvalid,
    input  logic       bready,
    // Memory port
    output logic       mem_req,
    output logic       mem_we,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    input  logic       mem_ack,
    input  word_t      mem_rdata
);

    // Registers to queue
    logic        push;
    dma_desc_t   push_data;
    logic        queue_empty;
    logic        queue_full;
    logic        queue_dropped;

    // Queue and controller
    logic        pop;
    dma_desc_t   pop_data;
    logic        run;
    logic        busy;
    logic [31:0] done_count;

    // Controller to mover
    logic        xfer_req;
    logic        xfer_ack;
    dma_desc_t   xfer_desc;

    // ==============================
    // Blocks
    // ==============================
    dma_csr_regs u_csr_regs (
        .clk, .reset_n,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready,
        .push, .push_data, .queue_empty, .queue_full, .queue_dropped,
        .busy, .done_count, .run
    );

    dma_desc_queue #(.T(dma_desc_t)) u_desc_queue (
        .clk, .reset_n,
        .push, .push_data, .pop, .pop_data,
        .empty   (queue_empty),
        .full    (queue_full),
        .dropped (queue_dropped)
    );

    dma_ctrl u_ctrl (
        .clk, .reset_n, .run, .queue_empty, .pop_data, .xfer_ack,
        .pop, .xfer_req, .xfer_desc, .busy, .done_count
    );

    dma_word_mover u_word_mover (
        .clk, .reset_n, .xfer_req, .xfer_desc, .xfer_ack,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

endmodule

`default_nettype wire

/* dma_tb.sv */
/* Testbench for the DMA copy engine. Drives AXI-lite register traffic, answers the
   memory port from a model and checks each copy against a reference memory. */

`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_tb
    import dma_regs_pkg::*, dma_xfer_pkg::*;
();

    // ==============================
    // Test sizes and limits
    // ==============================
    localparam int SEED      = 32'hc953;
    localparam int LEN_A     = 5;
    localparam int LEN_B     = 8;
    localparam int LEN_C     = 3;
    localparam int Q_LEN     = 4;
    localparam int LONG_LEN  = 40;
    localparam int MAX_POLLS = 2000;

    // Words actually copied over the whole run
    localparam int TOTAL_WORDS     = LEN_A + LEN_B + LEN_C + 4 * Q_LEN + LONG_LEN;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;

    logic       clk;
    logic       reset_n;
    logic       arvalid;
    logic       arready;
    logic [7:0] araddr;
    logic       rvalid;
    logic       rready;
    word_t      rdata;
    logic       awvalid;
    logic       awready;
    logic [7:0] awaddr;
    logic       wvalid;
    logic       wready;
    word_t      wdata;
    logic       bvalid;
    logic       bready;
    logic       mem_req;
    logic       mem_we;
    addr_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_ack;
    word_t      mem_rdata;

    // Memory model contents and the reference copy of it
    word_t      mem [addr_t];
    word_t      shadow [addr_t];
    int         write_count = 0;
    integer     data_seed = SEED;
    integer     lat_seed = SEED;

    dma_top u_dut (
        .clk, .reset_n,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Reference model
    // ==============================
    // Unwritten words read as a pattern built from the full address
    function automatic word_t fill_pattern(addr_t a);
        return {a, ~a, a ^ 16'hc3a5, addr_t'(a + 16'h1111)};
    endfunction

    function automatic word_t mem_word(addr_t a);
        return mem.exists(a) ? mem[a] : fill_pattern(a);
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_pattern(a);
    endfunction

    // Copies one descriptor word by word with addresses wrapping at the address width
    function automatic void copy_ref(addr_t src, addr_t dest, len_t len);
        addr_t s;
        addr_t d;
        for (int i = 0; i < int'(len); i++) begin
            s = addr_t'(src + i);
            d = addr_t'(dest + i);
            shadow[d] = shadow_word(s);
        end
    endfunction

    // ==============================
    // Checks
    // ==============================
    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Every word either side has touched must agree
    task automatic compare_memory();
        foreach (mem[a]) begin
            check($sformatf("mem[%h]", a), mem[a], shadow_word(a));
        end
        foreach (shadow[a]) begin
            check($sformatf("mem[%h]", a), mem_word(a), shadow[a]);
        end
    endtask

    // ==============================
    // AXI-lite driver
    // ==============================
    task automatic axi_write(input logic [4:0] idx, input word_t data);
        logic aw_go;
        logic w_go;
        awvalid = 1'b1;
        awaddr  = {idx, 3'b000};
        wvalid  = 1'b1;
        wdata   = data;
        // Each half leaves once its ready was seen before an edge
        while (awvalid || wvalid) begin
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            @(posedge clk);
            #1;
            if (aw_go) begin
                awvalid = 1'b0;
            end
            if (w_go) begin
                wvalid = 1'b0;
            end
        end
        bready = 1'b1;
        while (!bvalid) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] idx, output word_t data);
        arvalid = 1'b1;
        araddr  = {idx, 3'b000};
        while (!arready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) begin
            @(posedge clk);
            #1;
        end
        data = rdata;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic read_check(input logic [4:0] idx, input string name, input word_t expected);
        word_t rd;
        axi_read(idx, rd);
        check(name, rd, expected);
    endtask

    // Stage a descriptor and push it with the go bit
    task automatic program_desc(input addr_t src, input addr_t dest, input len_t len);
        axi_write(REG_SRC, word_t'(src));
        axi_write(REG_DEST, word_t'(dest));
        axi_write(REG_LEN, word_t'(len));
        axi_write(REG_DESC_CTRL, word_t'(1) << DESC_GO);
    endtask

    // Random source data written to both model and reference
    task automatic fill_words(input addr_t src, input int len);
        word_t w;
        addr_t a;
        for (int i = 0; i < len; i++) begin
            a         = addr_t'(src + i);
            w         = {$random(data_seed), $random(data_seed)};
            mem[a]    = w;
            shadow[a] = w;
        end
    endtask

    task automatic wait_done_count(input int target);
        word_t rd;
        int    polls;
        polls = 0;
        axi_read(REG_DONE_COUNT, rd);
        while (rd < word_t'(target)) begin
            polls++;
            if (polls > MAX_POLLS) begin
                $display("tests failed");
                $fatal(1, "done count never reached %0d, last read %0d", target, rd);
            end
            axi_read(REG_DONE_COUNT, rd);
        end
        check("done_count", rd, word_t'(target));
    endtask

    // ==============================
    // Memory model
    // ==============================
    initial begin : memory_model
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (reset_n && mem_req) begin
                delay = $unsigned($random(lat_seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_we) begin
                    mem[mem_addr] = mem_wdata;
                    write_count++;
                end else begin
                    mem_rdata = mem_word(mem_addr);
                end
                mem_ack = 1'b1;
                // Hold ack until the request is gone
                while (mem_req) begin
                    @(posedge clk);
                    #1;
                end
                mem_ack = 1'b0;
            end
        end
    end

    // Ends a hung run
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("tests failed");
        $fatal(1, "the run timed out after %0d cycles", WATCHDOG_CYCLES);
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin : main
        word_t rd;
        logic  saw_busy;
        int    base_writes;
        addr_t src;
        addr_t dest;
        reset_n = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;

        // Identity, status and handshake state after reset
        check("arready", word_t'(arready), word_t'(1));
        check("awready", word_t'(awready), word_t'(1));
        check("wready", word_t'(wready), word_t'(1));
        check("rvalid", word_t'(rvalid), word_t'(0));
        check("bvalid", word_t'(bvalid), word_t'(0));
        check("mem_req", word_t'(mem_req), word_t'(0));
        read_check(REG_DFH, "dfh", DFH_VALUE);
        read_check(REG_ID_L, "id_l", `DMA_ID_L);
        read_check(REG_ID_H, "id_h", `DMA_ID_H);
        read_check(REG_STATUS, "status", word_t'(1) << STAT_EMPTY);
        read_check(5'd20, "unmapped", '0);

        // Register readback
        axi_write(REG_SRC, 64'h1234);
        read_check(REG_SRC, "src", 64'h1234);
        axi_write(REG_DEST, 64'habcd);
        read_check(REG_DEST, "dest", 64'habcd);
        axi_write(REG_LEN, 64'h0042);
        read_check(REG_LEN, "len", 64'h0042);
        axi_write(REG_CONTROL, word_t'(1) << CTRL_RUN);
        read_check(REG_CONTROL, "control", word_t'(1) << CTRL_RUN);
        axi_write(REG_CONTROL, '0);
        read_check(REG_CONTROL, "control", '0);
        axi_write(REG_DESC_CTRL, 64'hfffe);
        read_check(REG_DESC_CTRL, "desc_ctrl", '0);

        // Three copies with run set where the last wraps past the top address
        fill_words(16'h1000, LEN_A);
        fill_words(16'h1100, LEN_B);
        fill_words(16'h1200, LEN_C);
        axi_write(REG_CONTROL, word_t'(1) << CTRL_RUN);
        program_desc(16'h1000, 16'h1800, len_t'(LEN_A));
        copy_ref(16'h1000, 16'h1800, len_t'(LEN_A));
        program_desc(16'h1100, 16'h1900, len_t'(LEN_B));
        copy_ref(16'h1100, 16'h1900, len_t'(LEN_B));
        program_desc(16'h1200, 16'hfffe, len_t'(LEN_C));
        copy_ref(16'h1200, 16'hfffe, len_t'(LEN_C));
        wait_done_count(3);
        compare_memory();

        // Queue overflow with run clear
        axi_write(REG_CONTROL, '0);
        for (int i = 0; i < 5; i++) begin
            fill_words(addr_t'(16'h2000 + i * 16'h100), Q_LEN);
        end
        for (int i = 0; i < 5; i++) begin
            src  = addr_t'(16'h2000 + i * 16'h100);
            // Fourth descriptor overwrites the first so order shows in memory
            dest = (i == 3) ? addr_t'(16'h3000) : addr_t'(16'h3000 + i * 16'h100);
            program_desc(src, dest, len_t'(Q_LEN));
            if (i < 4) begin
                copy_ref(src, dest, len_t'(Q_LEN));
            end
        end
        read_check(REG_STATUS, "status",
                   (word_t'(1) << STAT_FULL) | (word_t'(1) << STAT_OVERFLOW));
        axi_write(REG_CONTROL, word_t'(1) << CTRL_CLR_OVF);
        read_check(REG_STATUS, "status", word_t'(1) << STAT_FULL);
        axi_write(REG_CONTROL, word_t'(1) << CTRL_RUN);
        wait_done_count(7);
        repeat (100) @(posedge clk);
        #1;
        read_check(REG_DONE_COUNT, "done_count", word_t'(7));
        read_check(REG_STATUS, "status", word_t'(1) << STAT_EMPTY);
        compare_memory();

        // Busy seen during a long copy
        fill_words(16'h4000, LONG_LEN);
        program_desc(16'h4000, 16'h5000, len_t'(LONG_LEN));
        copy_ref(16'h4000, 16'h5000, len_t'(LONG_LEN));
        saw_busy = 1'b0;
        for (int n = 0; n < 40 && !saw_busy; n++) begin
            axi_read(REG_STATUS, rd);
            saw_busy = rd[STAT_BUSY];
        end
        check("status busy seen", word_t'(saw_busy), word_t'(1));
        wait_done_count(8);
        read_check(REG_STATUS, "status", word_t'(1) << STAT_EMPTY);
        compare_memory();

        // Zero length counts as done and touches no memory
        base_writes = write_count;
        program_desc(16'h6000, 16'h6100, '0);
        wait_done_count(9);
        check("mem writes", word_t'(write_count), word_t'(base_writes));
        read_check(REG_STATUS, "status", word_t'(1) << STAT_EMPTY);
        compare_memory();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dma_copy.f */
+incdir+.
dma_regs_pkg.sv
dma_xfer_pkg.sv
dma_csr_regs.sv
dma_desc_queue.sv
dma_ctrl.sv
dma_word_mover.sv
dma_top.sv
dma_tb.sv

/* Bender.yml */
package:
  name: dma_copy

sources:
  - include_dirs:
      - .
    files:
      - dma_regs_pkg.sv
      - dma_xfer_pkg.sv
      - dma_csr_regs.sv
      - dma_desc_queue.sv
      - dma_ctrl.sv
      - dma_word_mover.sv
      - dma_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dma_tb.sv
